// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the divider testbench with Verilator.
set -e

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
SIM_BIN=riscv_divider_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module riscv_divider_tb \
	-f vlog.f \
	--Mdir "$OBJ_DIR" -o "$SIM_BIN"

# keep running past assertion errors so the testbench can report them
"./$OBJ_DIR/$SIM_BIN" +verilator+error+limit+1000 | tee "$LOG"

if grep -qx "Test OK" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== sim/riscv_div_clkgen.sv ====
`timescale 1ns/100ps

module riscv_div_clkgen
#(
	parameter int PERIOD = 100,
	parameter int RST_CYCLES = 2
)
(
	output logic o_clk,
	output logic o_rst
);

	initial
	begin
		o_clk = 1'b0;
		forever #(PERIOD/2) o_clk = ~o_clk;
	end

	// active low, released between edges
	initial
	begin
		o_rst = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst = 1'b1;
	end

endmodule

// ==== sim/riscv_divider_chk.sv ====
`timescale 1ns/100ps

module riscv_divider_chk
	import riscv_div_pkg::*;
#(
	parameter int XLEN = 64
)
(
	input logic            i_clk,
	input logic            i_rst,
	input logic [2:0]      i_divctrl,
	input logic            i_busy,
	input logic [XLEN-1:0] i_result,
	input logic            i_valid
);

	localparam int LAT = XLEN + 3;  // sampled edges from accepting edge to valid seen high

	int   assert_fails = 0;
	logic accept;
	logic started;

	assign accept = i_divctrl[DIV_START_BIT] & ~i_busy;

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
			started <= 1'b0;
		else if (accept)
			started <= 1'b1;
	end

	quiet_after_reset: assert property (@(posedge i_clk) disable iff (!i_rst)
		!started |-> (!i_valid && i_result == '0))
	else
	begin
		assert_fails++;
		$error("valid or result active before first start");
	end

	valid_on_time: assert property (@(posedge i_clk) disable iff (!i_rst)
		$past(accept, LAT) |-> i_valid)
	else
	begin
		assert_fails++;
		$error("valid missing XLEN+2 cycles after start");
	end

	valid_has_cause: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_valid |-> $past(accept, LAT))
	else
	begin
		assert_fails++;
		$error("valid without a matching accepted start");
	end

	valid_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_valid |-> !$past(i_valid))
	else
	begin
		assert_fails++;
		$error("valid held longer than one cycle");
	end

endmodule

// ==== sim/riscv_divider_tb.sv ====
`timescale 1ns/100ps

module riscv_divider_tb
	import riscv_div_pkg::*;
();

	localparam int XLEN = 64;
	localparam int N_FIXED = 20;
	localparam int N_RAND = 16;
	localparam int NUM_TESTS = N_FIXED + N_RAND + 3;  // busy test spans about three divisions
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 70 + 100;
	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	logic            div_clk;
	logic            div_rst;
	logic [2:0]      divctrl;
	logic [XLEN-1:0] rs1data;
	logic [XLEN-1:0] rs2data;
	logic [XLEN-1:0] result;
	logic            valid;
	logic [63:0]     seed;
	logic [XLEN-1:0] rand_a;
	logic [XLEN-1:0] rand_b;
	div_op_e         rand_op;
	int              errors;

	riscv_div_clkgen #(.PERIOD(100), .RST_CYCLES(2)) u_clkgen (
		.o_clk (div_clk),
		.o_rst (div_rst)
	);

	riscv_divider #(.XLEN(XLEN)) dut (
		.i_riscv_div_clk     (div_clk),
		.i_riscv_div_rst     (div_rst),
		.i_riscv_div_divctrl (divctrl),
		.i_riscv_div_rs1data (rs1data),
		.i_riscv_div_rs2data (rs2data),
		.o_riscv_div_result  (result),
		.o_riscv_div_valid   (valid)
	);

	bind riscv_divider riscv_divider_chk #(.XLEN(XLEN)) u_chk (
		.i_clk     (i_riscv_div_clk),
		.i_rst     (i_riscv_div_rst),
		.i_divctrl (i_riscv_div_divctrl),
		.i_busy    (busy),
		.i_result  (o_riscv_div_result),
		.i_valid   (o_riscv_div_valid)
	);

	function automatic logic [63:0] lcg_next(input logic [63:0] s);
		return s * 64'd6364136223846793005 + 64'd1442695040888963407;
	endfunction

	// special cases first, then the simulator's own division
	function automatic logic [XLEN-1:0] expected_result(input div_op_e op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic            is_unsigned;
		logic [XLEN-1:0] q;
		logic [XLEN-1:0] r;
		is_unsigned = (op == DIV_OP_DIVU) || (op == DIV_OP_REMU);
		if (b == '0)
		begin
			q = '1;
			r = a;
		end
		else if (!is_unsigned && a == MOST_NEG && b == '1)
		begin
			q = a;
			r = '0;
		end
		else if (is_unsigned)
		begin
			q = a / b;
			r = a % b;
		end
		else
		begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);  // sign of dividend
		end
		return (op == DIV_OP_REM || op == DIV_OP_REMU) ? r : q;
	endfunction

	task automatic start_div(input div_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		@(negedge div_clk);
		divctrl = {1'b1, op};
		rs1data = a;
		rs2data = b;
		@(negedge div_clk);
		divctrl = 3'b000;
		rs1data = ~a;  // operands must already be captured
		rs2data = ~b;
	endtask

	task automatic check_result(input logic [XLEN-1:0] exp);
		int cycles;
		cycles = 0;
		while (!valid && cycles < XLEN + 8)
		begin
			@(negedge div_clk);
			cycles++;
		end
		if (!valid)
		begin
			$display("no valid pulse seen after start at %0t", $time);
			errors++;
		end
		else
		begin
			result_match: assert (result === exp)
			else
			begin
				$display("error %0t o_riscv_div_result expected %h actual %h",
					$time, exp, result);
				errors++;
			end
		end
	endtask

	task automatic run_div(input div_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		start_div(op, a, b);
		check_result(expected_result(op, a, b));
	endtask

	// second start lands mid division and must be dropped
	task automatic run_busy(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
		input logic [XLEN-1:0] c, input logic [XLEN-1:0] d);
		logic extra;
		extra = 1'b0;
		start_div(DIV_OP_DIV, a, b);
		repeat (10) @(negedge div_clk);
		divctrl = {1'b1, DIV_OP_REMU};
		rs1data = c;
		rs2data = d;
		@(negedge div_clk);
		divctrl = 3'b000;
		check_result(expected_result(DIV_OP_DIV, a, b));
		@(negedge div_clk);
		repeat (XLEN + 4)
		begin
			if (valid)
				extra = 1'b1;
			@(negedge div_clk);
		end
		if (extra)
		begin
			$display("a start given while busy produced a second result at %0t", $time);
			errors++;
		end
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge div_clk);
		$display("watchdog: run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		divctrl = 3'b000;
		rs1data = '0;
		rs2data = '0;
		errors = 0;
		seed = 64'd94;
		@(posedge div_rst);
		repeat (4) @(negedge div_clk);
		idle_result: assert (result == '0)
		else
		begin
			$display("error %0t o_riscv_div_result expected %h actual %h",
				$time, '0, result);
			errors++;
		end
		if (valid)
		begin
			$display("valid high after reset with no start at %0t", $time);
			errors++;
		end

		run_div(DIV_OP_DIV, 64'd100, 64'd7);
		run_div(DIV_OP_DIV, -64'd100, 64'd7);
		run_div(DIV_OP_DIV, 64'd100, -64'd7);
		run_div(DIV_OP_DIV, -64'd100, -64'd7);
		run_div(DIV_OP_REM, 64'd100, 64'd7);
		run_div(DIV_OP_REM, -64'd100, 64'd7);
		run_div(DIV_OP_REM, 64'd100, -64'd7);
		run_div(DIV_OP_REM, -64'd100, -64'd7);

		for (int i = 0; i < N_RAND; i++)
		begin
			seed = lcg_next(seed);
			rand_a = seed;
			seed = lcg_next(seed);
			rand_b = seed >> seed[63:58];  // spread of divisor sizes
			if (seed[55])
				rand_b = -rand_b;
			rand_op = div_op_e'(seed[54:53]);
			run_div(rand_op, rand_a, rand_b);
		end

		run_div(DIV_OP_DIVU, 64'hFFFF_FFFF_FFFF_FFF0, 64'h8000_0000_0000_0001);
		run_div(DIV_OP_REMU, 64'hFFFF_FFFF_FFFF_FFF0, 64'h8000_0000_0000_0001);
		run_div(DIV_OP_DIVU, 64'd5, 64'h8000_0000_0000_0000);
		run_div(DIV_OP_REMU, 64'd5, 64'h8000_0000_0000_0000);
		run_div(DIV_OP_DIVU, 64'd3, 64'd10);
		run_div(DIV_OP_REMU, 64'd3, 64'd10);

		run_div(DIV_OP_DIV, 64'h1234, '0);
		run_div(DIV_OP_DIVU, MOST_NEG, '0);
		run_div(DIV_OP_REM, -64'd5, '0);
		run_div(DIV_OP_REMU, 64'hDEAD_BEEF, '0);
		run_div(DIV_OP_DIV, MOST_NEG, '1);
		run_div(DIV_OP_REM, MOST_NEG, '1);

		run_busy(64'd1000, 64'd3, 64'd77, 64'd5);

		$display("checks done: %0d errors, %0d assertion failures", errors, dut.u_chk.assert_fails);
		if (errors == 0 && dut.u_chk.assert_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== verilog/riscv_div_core.sv ====
`timescale 1ns/100ps

module riscv_div_core
	import riscv_div_pkg::*;
#(
	parameter int XLEN = 64
)
(
	input  logic            i_riscv_div_clk,
	input  logic            i_riscv_div_rst,
	input  logic            i_load,
	input  logic [XLEN-1:0] i_dividend_mag,
	input  logic [XLEN-1:0] i_divisor_mag,
	output logic            o_busy,
	output logic            o_done,
	output logic [XLEN-1:0] o_quotient,
	output logic [XLEN-1:0] o_remainder
);

	localparam int CNT_W = div_cnt_bits(XLEN);
	localparam logic IDLE = 1'b0;
	localparam logic RUN = 1'b1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(XLEN - 1);

	logic              state;
	logic [CNT_W-1:0]  cnt;
	logic [2*XLEN-1:0] partial;  // remainder high, quotient low
	logic [XLEN-1:0]   divisor;
	logic [XLEN:0]     shifted_hi;
	logic [XLEN:0]     diff;
	logic [2*XLEN-1:0] partial_next;

	// shift left, try subtract on the upper half
	always_comb
	begin
		shifted_hi = partial[2*XLEN-1:XLEN-1];  // keeps the bit shifted out
		diff = shifted_hi - {1'b0, divisor};
		if (diff[XLEN])
		begin
			partial_next = {shifted_hi[XLEN-1:0], partial[XLEN-2:0], 1'b0};
		end
		else
		begin
			partial_next = {diff[XLEN-1:0], partial[XLEN-2:0], 1'b1};
		end
	end

	always_ff @(posedge i_riscv_div_clk or negedge i_riscv_div_rst)
	begin
		if (!i_riscv_div_rst)
		begin
			state <= IDLE;
			cnt <= '0;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				IDLE:
				begin
					if (i_load)
					begin
						state <= RUN;
						cnt <= '0;
					end
				end
				RUN:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == LAST)
					begin
						state <= IDLE;
						o_done <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_riscv_div_clk)
	begin
		if (state == IDLE && i_load)
		begin
			partial <= {{XLEN{1'b0}}, i_dividend_mag};
			divisor <= i_divisor_mag;
		end
		else if (state == RUN)
		begin
			partial <= partial_next;
		end
	end

	assign o_busy = (state == RUN) | i_load;  // covers the load cycle too
	assign o_quotient = partial[XLEN-1:0];
	assign o_remainder = partial[2*XLEN-1:XLEN];

endmodule

// ==== verilog/riscv_div_operand_latch.sv ====
`timescale 1ns/100ps

module riscv_div_operand_latch
	import riscv_div_pkg::*;
#(
	parameter int XLEN = 64
)
(
	input  logic            i_riscv_div_clk,
	input  logic            i_riscv_div_rst,
	input  logic [2:0]      i_riscv_div_divctrl,
	input  logic [XLEN-1:0] i_riscv_div_rs1data,
	input  logic [XLEN-1:0] i_riscv_div_rs2data,
	input  logic            i_busy,
	output logic            o_load,
	output logic [XLEN-1:0] o_dividend_mag,
	output logic [XLEN-1:0] o_divisor_mag,
	output div_op_e         o_op,
	output logic            o_dividend_neg,
	output logic            o_quot_neg,
	output logic            o_div_zero,
	output logic            o_overflow,
	output logic [XLEN-1:0] o_dividend_raw
);

	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	logic            accept;
	div_op_e         op_in;
	logic            is_signed;
	logic            rs1_neg;
	logic            rs2_neg;
	logic [XLEN-1:0] rs1_mag;
	logic [XLEN-1:0] rs2_mag;
	logic            div_zero;
	logic            overflow;

	assign accept = i_riscv_div_divctrl[DIV_START_BIT] & ~i_busy;  // no queueing
	assign op_in = div_op_e'(i_riscv_div_divctrl[1:0]);
	assign is_signed = ~op_in[0];

	always_comb
	begin
		rs1_neg = is_signed & i_riscv_div_rs1data[XLEN-1];
		rs2_neg = is_signed & i_riscv_div_rs2data[XLEN-1];
		rs1_mag = rs1_neg ? -i_riscv_div_rs1data : i_riscv_div_rs1data;
		rs2_mag = rs2_neg ? -i_riscv_div_rs2data : i_riscv_div_rs2data;
		div_zero = (i_riscv_div_rs2data == '0);
		// most negative by -1 wraps in two's complement
		overflow = is_signed & (i_riscv_div_rs1data == MOST_NEG) &
			(&i_riscv_div_rs2data);
	end

	// control and flags, held until the next accepted start
	always_ff @(posedge i_riscv_div_clk or negedge i_riscv_div_rst)
	begin
		if (!i_riscv_div_rst)
		begin
			o_load <= 1'b0;
			o_op <= DIV_OP_DIV;
			o_dividend_neg <= 1'b0;
			o_quot_neg <= 1'b0;
			o_div_zero <= 1'b0;
			o_overflow <= 1'b0;
		end
		else
		begin
			o_load <= accept;  // one cycle pulse
			if (accept)
			begin
				o_op <= op_in;
				o_dividend_neg <= rs1_neg;
				o_quot_neg <= rs1_neg ^ rs2_neg;
				o_div_zero <= div_zero;
				o_overflow <= overflow;
			end
		end
	end

	// operand payload
	always_ff @(posedge i_riscv_div_clk)
	begin
		if (accept)
		begin
			o_dividend_mag <= rs1_mag;
			o_divisor_mag <= rs2_mag;
			o_dividend_raw <= i_riscv_div_rs1data;
		end
	end

endmodule

// ==== verilog/riscv_div_pkg.sv ====
package riscv_div_pkg;

	// divctrl[1:0], bit 0 unsigned, bit 1 remainder
	typedef enum logic [1:0] {
		DIV_OP_DIV  = 2'b00,
		DIV_OP_DIVU = 2'b01,
		DIV_OP_REM  = 2'b10,
		DIV_OP_REMU = 2'b11
	} div_op_e;

	// start strobe position in divctrl
	localparam int DIV_START_BIT = 2;

	// one quotient bit per cycle, so the counter spans the operand width
	function automatic int div_cnt_bits(input int width);
		int bits;
		bits = $clog2(width);
		if (bits < 1)
		begin
			bits = 1;
		end
		return bits;
	endfunction

endpackage

// ==== verilog/riscv_div_result.sv ====
`timescale 1ns/100ps

module riscv_div_result
	import riscv_div_pkg::*;
#(
	parameter int XLEN = 64
)
(
	input  logic            i_riscv_div_clk,
	input  logic            i_riscv_div_rst,
	input  logic            i_done,
	input  logic [XLEN-1:0] i_quotient,
	input  logic [XLEN-1:0] i_remainder,
	input  div_op_e         i_op,
	input  logic            i_dividend_neg,
	input  logic            i_quot_neg,
	input  logic            i_div_zero,
	input  logic            i_overflow,
	input  logic [XLEN-1:0] i_dividend_raw,
	output logic [XLEN-1:0] o_riscv_div_result,
	output logic            o_riscv_div_valid
);

	logic [XLEN-1:0] quot_fix;
	logic [XLEN-1:0] rem_fix;
	logic [XLEN-1:0] quot_sel;
	logic [XLEN-1:0] rem_sel;
	logic [XLEN-1:0] result_next;

	always_comb
	begin
		quot_fix = i_quot_neg ? -i_quotient : i_quotient;
		rem_fix = i_dividend_neg ? -i_remainder : i_remainder;  // follows dividend sign

		if (i_div_zero)
		begin
			quot_sel = '1;
			rem_sel = i_dividend_raw;
		end
		else if (i_overflow)
		begin
			quot_sel = i_dividend_raw;
			rem_sel = '0;
		end
		else
		begin
			quot_sel = quot_fix;
			rem_sel = rem_fix;
		end

		case (i_op)
			DIV_OP_DIV, DIV_OP_DIVU:
			begin
				result_next = quot_sel;
			end
			DIV_OP_REM, DIV_OP_REMU:
			begin
				result_next = rem_sel;
			end
			default:
			begin
				result_next = quot_sel;
			end
		endcase
	end

	always_ff @(posedge i_riscv_div_clk or negedge i_riscv_div_rst)
	begin
		if (!i_riscv_div_rst)
		begin
			o_riscv_div_result <= '0;
			o_riscv_div_valid <= 1'b0;
		end
		else
		begin
			o_riscv_div_valid <= i_done;
			if (i_done)
			begin
				o_riscv_div_result <= result_next;  // held until next valid
			end
		end
	end

endmodule

// ==== verilog/riscv_divider.sv ====
`timescale 1ns/100ps

module riscv_divider
	import riscv_div_pkg::*;
#(
	parameter int XLEN = 64
)
(
	input  logic            i_riscv_div_clk,
	input  logic            i_riscv_div_rst,
	input  logic [2:0]      i_riscv_div_divctrl,
	input  logic [XLEN-1:0] i_riscv_div_rs1data,
	input  logic [XLEN-1:0] i_riscv_div_rs2data,
	output logic [XLEN-1:0] o_riscv_div_result,
	output logic            o_riscv_div_valid
);

	logic            load;
	logic            busy;
	logic            done;
	logic [XLEN-1:0] dividend_mag;
	logic [XLEN-1:0] divisor_mag;
	logic [XLEN-1:0] quotient;
	logic [XLEN-1:0] remainder;
	div_op_e         op;
	logic            dividend_neg;
	logic            quot_neg;
	logic            div_zero;
	logic            overflow;
	logic [XLEN-1:0] dividend_raw;

	riscv_div_operand_latch #(.XLEN(XLEN)) u_latch (
		.i_riscv_div_clk     (i_riscv_div_clk),
		.i_riscv_div_rst     (i_riscv_div_rst),
		.i_riscv_div_divctrl (i_riscv_div_divctrl),
		.i_riscv_div_rs1data (i_riscv_div_rs1data),
		.i_riscv_div_rs2data (i_riscv_div_rs2data),
		.i_busy              (busy),
		.o_load              (load),
		.o_dividend_mag      (dividend_mag),
		.o_divisor_mag       (divisor_mag),
		.o_op                (op),
		.o_dividend_neg      (dividend_neg),
		.o_quot_neg          (quot_neg),
		.o_div_zero          (div_zero),
		.o_overflow          (overflow),
		.o_dividend_raw      (dividend_raw)
	);

	riscv_div_core #(.XLEN(XLEN)) u_core (
		.i_riscv_div_clk (i_riscv_div_clk),
		.i_riscv_div_rst (i_riscv_div_rst),
		.i_load          (load),
		.i_dividend_mag  (dividend_mag),
		.i_divisor_mag   (divisor_mag),
		.o_busy          (busy),
		.o_done          (done),
		.o_quotient      (quotient),
		.o_remainder     (remainder)
	);

	riscv_div_result #(.XLEN(XLEN)) u_result (
		.i_riscv_div_clk    (i_riscv_div_clk),
		.i_riscv_div_rst    (i_riscv_div_rst),
		.i_done             (done),
		.i_quotient         (quotient),
		.i_remainder        (remainder),
		.i_op               (op),
		.i_dividend_neg     (dividend_neg),
		.i_quot_neg         (quot_neg),
		.i_div_zero         (div_zero),
		.i_overflow         (overflow),
		.i_dividend_raw     (dividend_raw),
		.o_riscv_div_result (o_riscv_div_result),
		.o_riscv_div_valid  (o_riscv_div_valid)
	);

endmodule

// ==== vlog.f ====
verilog/riscv_div_pkg.sv
verilog/riscv_div_operand_latch.sv
verilog/riscv_div_core.sv
verilog/riscv_div_result.sv
verilog/riscv_divider.sv
sim/riscv_div_clkgen.sv
sim/riscv_divider_chk.sv
sim/riscv_divider_tb.sv
